//--- common/histPkg.sv
`default_nettype none

package histPkg;

    // array geometry
    localparam int pixNum = 4;
    localparam int binNum = 16;

    typedef logic [1:0]  pixT;
    typedef logic [3:0]  binT;
    typedef logic [15:0] countT;
    // pixel index above the bin index
    typedef logic [5:0]  ramAddrT;

    // one hit from the pixel array
    typedef struct packed {
        pixT pixel;
        binT bin;
    } hitT;

    // request a client hands to the arbiter
    typedef struct packed {
        logic    rdEn;
        ramAddrT rdAddr;
        logic    wrEn;
        ramAddrT wrAddr;
        countT   wrData;
    } memReqT;

    // per pixel result of a scan
    typedef struct packed {
        binT   bin;
        countT count;
    } peakT;

    typedef enum logic [1:0] {
        bldIdle,
        bldRun,
        bldClear
    } builderStateT;

    typedef enum logic [1:0] {
        pkIdle,
        pkScan,
        pkDone
    } peakStateT;

    // host register map, byte offsets
    localparam logic [31:0] regCtrl     = 32'h0000_0000;
    localparam logic [31:0] regStatus   = 32'h0000_0004;
    localparam logic [31:0] regHitCount = 32'h0000_0008;
    localparam logic [31:0] regPeakBase = 32'h0000_0100;
    localparam logic [31:0] regHistBase = 32'h0000_1000;

endpackage

`default_nettype wire

//--- verilog/histRam.sv
`timescale 1ns/100ps
`default_nettype none

module histRam import histPkg::*; (
    input  wire         clk,
    input  wire memReqT req,
    output countT       rdData
);

    // pixel-major count words
    countT mem [pixNum*binNum];

    // write port
    always_ff @(posedge clk) begin
        if (req.wrEn) begin
            mem[req.wrAddr] <= req.wrData;
        end
    end

    // registered read
    // old word comes back when the same address is written on that edge
    always_ff @(posedge clk) begin
        if (req.rdEn) begin
            rdData <= mem[req.rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/ramArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module ramArbiter import histPkg::*; (
    input  wire               clk,
    input  wire               res,
    input  wire [2:0]         reqs,
    input  wire memReqT [2:0] memReqs,
    output logic [2:0]        grants,
    output memReqT            ramReq
);

    // one-hot owner, all zero when nobody holds the memory
    logic [2:0] owner;
    logic [2:0] pick;

    // fixed priority: builder, peak finder, host
    always_comb begin
        pick = 3'b000;
        if (reqs[0]) begin
            pick = 3'b001;
        end else if (reqs[1]) begin
            pick = 3'b010;
        end else if (reqs[2]) begin
            pick = 3'b100;
        end
    end

    // owner keeps the memory while its req stays up
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            owner <= 3'b001;
        end else if ((owner & reqs) == 3'b000) begin
            owner <= pick;
        end
    end

    assign grants = owner;

    // route the owner's request, idle request otherwise
    always_comb begin
        ramReq = '0;
        for (int i = 0; i < 3; i++) begin
            if (owner[i]) begin
                ramReq = memReqs[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- histBuilder/histBuilder.sv
`timescale 1ns/100ps
`default_nettype none

module histBuilder import histPkg::*; (
    input  wire         clk,
    input  wire         res,
    input  wire         hitValid,
    output logic        hitReady,
    input  wire hitT    hit,
    input  wire         clearStart,
    input  wire         grant,
    output logic        req,
    output memReqT      memReq,
    input  wire countT  rdData,
    input  wire         otherWaiting,
    output logic        clearBusy,
    output logic [31:0] hitCount
);

    builderStateT state;
    logic    clearPend;
    logic    clearReq;
    logic    enterClear;
    logic    pipeEmpty;
    logic    yield;
    logic    accept;
    ramAddrT clrAddr;

    // stage 1 issues the read, stage 2 writes the increment
    logic    s1Valid;
    logic    s2Valid;
    ramAddrT s1Addr;
    ramAddrT s2Addr;
    // stage 2 of the previous cycle wrote the address stage 1 just read
    logic    fwdHit;
    countT   fwdData;
    countT   baseCount;

    assign clearReq   = clearStart | clearPend;
    assign enterClear = clearReq && grant && (state != bldClear);
    assign pipeEmpty  = !s1Valid && !s2Valid;
    // hand the memory over once drained
    assign yield      = (state == bldRun) && otherWaiting && pipeEmpty && !clearReq;
    assign req        = !yield;
    // stop taking hits so a waiting client is not starved
    assign hitReady   = (state == bldRun) && grant && !otherWaiting && !clearReq;
    assign accept     = hitValid && hitReady;
    assign clearBusy  = clearPend || (state == bldClear);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= bldIdle;
            clearPend <= 1'b0;
            clrAddr   <= '0;
        end else begin
            // hold a clear request until the grant comes
            clearPend <= clearReq && !enterClear;
            case (state)
                bldIdle: begin
                    if (enterClear) begin
                        state <= bldClear;
                    end else if (grant) begin
                        state <= bldRun;
                    end
                end
                bldRun: begin
                    if (enterClear) begin
                        state <= bldClear;
                    end else if (yield) begin
                        state <= bldIdle;
                    end
                end
                bldClear: begin
                    // one zero word per cycle, wraps back to 0
                    clrAddr <= clrAddr + 1'b1;
                    if (clrAddr == '1) begin
                        state <= bldRun;
                    end
                end
                default: begin
                    state <= bldIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid  <= 1'b0;
            s2Valid  <= 1'b0;
            fwdHit   <= 1'b0;
            hitCount <= '0;
        end else begin
            s1Valid <= accept;
            // in-flight hits are dropped by a clear
            s2Valid <= s1Valid && !enterClear;
            fwdHit  <= s1Valid && s2Valid && (s1Addr == s2Addr);
            if (enterClear) begin
                hitCount <= '0;
            end else if (accept) begin
                hitCount <= hitCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1Addr <= {hit.pixel, hit.bin};
        end
        s2Addr  <= s1Addr;
        fwdData <= memReq.wrData;
    end

    // memory read-first, so the word written on the read edge is forwarded
    assign baseCount = fwdHit ? fwdData : rdData;

    always_comb begin
        memReq = '0;
        if (state == bldClear) begin
            memReq.wrEn   = 1'b1;
            memReq.wrAddr = clrAddr;
        end else begin
            memReq.rdEn   = s1Valid;
            memReq.rdAddr = s1Addr;
            memReq.wrEn   = s2Valid;
            memReq.wrAddr = s2Addr;
            memReq.wrData = baseCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- peakFinder/peakFinder.sv
`timescale 1ns/100ps
`default_nettype none

module peakFinder import histPkg::*; (
    input  wire               clk,
    input  wire               res,
    input  wire               start,
    input  wire               grant,
    output logic              req,
    output memReqT            memReq,
    input  wire countT        rdData,
    output peakT [pixNum-1:0] peaks,
    output logic              peakBusy,
    output logic              peakDone
);

    peakStateT state;
    ramAddrT   issueAddr;
    logic      issuedAll;
    logic      issue;
    // address of the word now on rdData
    logic      retValid;
    ramAddrT   retAddr;
    pixT       retPix;
    binT       retBin;
    // running maximum of the current pixel
    countT     maxCount;
    binT       maxBin;
    logic      better;
    countT     nextCount;
    binT       nextBin;

    assign req      = (state == pkScan);
    assign peakBusy = (state == pkScan);
    assign peakDone = (state == pkDone);
    assign issue    = (state == pkScan) && grant && !issuedAll;
    assign {retPix, retBin} = retAddr;

    always_comb begin
        memReq        = '0;
        memReq.rdEn   = issue;
        memReq.rdAddr = issueAddr;
    end

    // bin 0 seeds the maximum
    // only a strictly larger count moves it, lowest bin keeps a tie
    assign better    = (retBin == '0) || (rdData > maxCount);
    assign nextCount = better ? rdData : maxCount;
    assign nextBin   = better ? retBin : maxBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= pkIdle;
            issueAddr <= '0;
            issuedAll <= 1'b0;
            retValid  <= 1'b0;
            peaks     <= '0;
        end else begin
            retValid <= issue;
            case (state)
                pkIdle, pkDone: begin
                    // start also drops peakDone
                    if (start) begin
                        state     <= pkScan;
                        issueAddr <= '0;
                        issuedAll <= 1'b0;
                    end
                end
                pkScan: begin
                    if (issue) begin
                        issueAddr <= issueAddr + 1'b1;
                        if (issueAddr == '1) begin
                            issuedAll <= 1'b1;
                        end
                    end
                    // last word of the last pixel
                    if (retValid && (retAddr == '1)) begin
                        state <= pkDone;
                    end
                end
                default: begin
                    state <= pkIdle;
                end
            endcase
            // winner stored at the pixel's last bin
            if (retValid && (retBin == binT'(binNum - 1))) begin
                peaks[retPix].bin   <= nextBin;
                peaks[retPix].count <= nextCount;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            retAddr <= issueAddr;
        end
        if (retValid) begin
            maxCount <= nextCount;
            maxBin   <= nextBin;
        end
    end

endmodule

`default_nettype wire

//--- verilog/axiLiteRegs.sv
`timescale 1ns/100ps
`default_nettype none

module axiLiteRegs import histPkg::*; (
    input  wire                    clk,
    input  wire                    res,
    input  wire [31:0]             awaddr,
    input  wire                    awvalid,
    output logic                   awready,
    input  wire [31:0]             wdata,
    input  wire                    wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  wire                    bready,
    input  wire [31:0]             araddr,
    input  wire                    arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic                   rvalid,
    input  wire                    rready,
    output logic                   clearStart,
    output logic                   peakStart,
    input  wire                    grant,
    output logic                   req,
    output memReqT                 memReq,
    input  wire countT             rdData,
    input  wire                    clearBusy,
    input  wire                    peakBusy,
    input  wire                    peakDone,
    input  wire [31:0]             hitCount,
    input  wire peakT [pixNum-1:0] peaks
);

    logic        wrFire;
    logic        rdFire;
    logic        histSel;
    // histogram read waiting for the grant, then for the data
    logic        histPend;
    logic        histCapture;
    ramAddrT     histAddr;
    logic [31:0] regValue;
    peakT        peakSel;

    // address and data taken together, nothing new while bvalid is up
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign wrFire  = awready;

    // one read in flight at a time
    assign arready = arvalid && !rvalid && !histPend && !histCapture;
    assign rdFire  = arready;
    assign histSel = (araddr[31:8] == regHistBase[31:8]);
    assign peakSel = peaks[araddr[3:2]];
    assign req     = histPend;

    always_comb begin
        memReq        = '0;
        memReq.rdEn   = histPend && grant;
        memReq.rdAddr = histAddr;
    end

    // register read mux, unmapped reads give zero
    always_comb begin
        regValue = '0;
        if (araddr == regStatus) begin
            regValue = {29'b0, peakDone, peakBusy, clearBusy};
        end else if (araddr == regHitCount) begin
            regValue = hitCount;
        end else if (araddr[31:4] == regPeakBase[31:4]) begin
            regValue = {peakSel.count, 12'b0, peakSel.bin};
        end
    end

    // write channel, start pulses line up with bvalid rising
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bvalid     <= 1'b0;
            clearStart <= 1'b0;
            peakStart  <= 1'b0;
        end else begin
            clearStart <= wrFire && (awaddr == regCtrl) && wdata[0];
            peakStart  <= wrFire && (awaddr == regCtrl) && wdata[1];
            if (wrFire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read channel
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rvalid      <= 1'b0;
            histPend    <= 1'b0;
            histCapture <= 1'b0;
        end else begin
            histCapture <= histPend && grant;
            if (rdFire && histSel) begin
                histPend <= 1'b1;
            end else if (histPend && grant) begin
                histPend <= 1'b0;
            end
            if ((rdFire && !histSel) || histCapture) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            histAddr <= araddr[7:2];
        end
        // memory word arrives the cycle after the granted read
        if (rdFire && !histSel) begin
            rdata <= regValue;
        end else if (histCapture) begin
            rdata <= {16'b0, rdData};
        end
    end

endmodule

`default_nettype wire

//--- verilog/histTop.sv
`timescale 1ns/100ps
`default_nettype none

module histTop import histPkg::*; (
    input  wire        clk,
    input  wire        res,
    input  wire        hitValid,
    output logic       hitReady,
    input  wire hitT   hit,
    input  wire [31:0] awaddr,
    input  wire        awvalid,
    output logic       awready,
    input  wire [31:0] wdata,
    input  wire        wvalid,
    output logic       wready,
    output logic       bvalid,
    input  wire        bready,
    input  wire [31:0] araddr,
    input  wire        arvalid,
    output logic       arready,
    output logic [31:0] rdata,
    output logic       rvalid,
    input  wire        rready
);

    // client 0 builder, 1 peak finder, 2 host
    logic [2:0]        reqs;
    logic [2:0]        grants;
    memReqT [2:0]      memReqs;
    memReqT            ramReq;
    countT             rdData;
    logic              otherWaiting;
    logic              clearStart;
    logic              peakStart;
    logic              clearBusy;
    logic              peakBusy;
    logic              peakDone;
    logic [31:0]       hitCount;
    peakT [pixNum-1:0] peaks;

    // builder yields when either other client asks
    assign otherWaiting = reqs[1] | reqs[2];

    histRam histRam_inst (
        .clk    (clk),
        .req    (ramReq),
        .rdData (rdData)
    );

    ramArbiter ramArbiter_inst (
        .clk     (clk),
        .res     (res),
        .reqs    (reqs),
        .memReqs (memReqs),
        .grants  (grants),
        .ramReq  (ramReq)
    );

    histBuilder histBuilder_inst (
        .clk          (clk),
        .res          (res),
        .hitValid     (hitValid),
        .hitReady     (hitReady),
        .hit          (hit),
        .clearStart   (clearStart),
        .grant        (grants[0]),
        .req          (reqs[0]),
        .memReq       (memReqs[0]),
        .rdData       (rdData),
        .otherWaiting (otherWaiting),
        .clearBusy    (clearBusy),
        .hitCount     (hitCount)
    );

    peakFinder peakFinder_inst (
        .clk      (clk),
        .res      (res),
        .start    (peakStart),
        .grant    (grants[1]),
        .req      (reqs[1]),
        .memReq   (memReqs[1]),
        .rdData   (rdData),
        .peaks    (peaks),
        .peakBusy (peakBusy),
        .peakDone (peakDone)
    );

    axiLiteRegs axiLiteRegs_inst (
        .clk        (clk),
        .res        (res),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .clearStart (clearStart),
        .peakStart  (peakStart),
        .grant      (grants[2]),
        .req        (reqs[2]),
        .memReq     (memReqs[2]),
        .rdData     (rdData),
        .clearBusy  (clearBusy),
        .peakBusy   (peakBusy),
        .peakDone   (peakDone),
        .hitCount   (hitCount),
        .peaks      (peaks)
    );

endmodule

`default_nettype wire

//--- tb/histTb.sv
`timescale 1ns/100ps
`default_nettype none

module histTb import histPkg::*; ();

    logic        clk;
    logic        res;
    logic        hitValid;
    logic        hitReady;
    hitT         hit;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;

    int errCnt;
    int checkCnt;
    int seed;
    int expHits;
    // expected count per memory address
    int model [pixNum*binNum];

    histTop histTop_inst (
        .clk      (clk),
        .res      (res),
        .hitValid (hitValid),
        .hitReady (hitReady),
        .hit      (hit),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rready   (rready)
    );

    always #10 clk = ~clk;

    // no hit taken while a scan or a clear owns the memory
    assert property (@(posedge clk) disable iff (!res)
        hitReady |-> !(histTop_inst.peakBusy || histTop_inst.clearBusy))
        else begin
            $display("[FAIL] hitReady %h with peakBusy %h clearBusy %h", hitReady,
                histTop_inst.peakBusy, histTop_inst.clearBusy);
            errCnt++;
        end

    // responses wait for the master
    assert property (@(posedge clk) disable iff (!res) bvalid && !bready |=> bvalid)
        else begin
            $display("[FAIL] bvalid dropped to %h before bready", bvalid);
            errCnt++;
        end

    assert property (@(posedge clk) disable iff (!res)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $display("[FAIL] rvalid %h rdata %h changed before rready", rvalid, rdata);
            errCnt++;
        end

    task automatic abortOnTimeout(input string what);
        $display("timeout while waiting for %s", what);
        errCnt++;
        $display("checks %0d errors %0d", checkCnt, errCnt);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCnt++;
        assert (got == exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errCnt++;
        end
    endtask

    // hold > 0 keeps bready low that many cycles after bvalid
    task automatic writeReg(input logic [31:0] addr, input logic [31:0] data, input int hold);
        int waitCnt;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        waitCnt = 0;
        @(negedge clk);
        while (!(awready && wready)) begin
            waitCnt++;
            if (waitCnt > 200) begin
                abortOnTimeout("awready and wready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (!bvalid) begin
            waitCnt++;
            if (waitCnt > 200) begin
                abortOnTimeout("bvalid");
            end
            @(negedge clk);
        end
        if (hold > 0) begin
            repeat (hold) @(posedge clk);
            #2;
            checkEq("bvalid", 32'(bvalid), 32'h1);
            bready = 1'b1;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic readReg(input logic [31:0] addr, input int hold, output logic [31:0] data);
        int waitCnt;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        waitCnt = 0;
        @(negedge clk);
        while (!arready) begin
            waitCnt++;
            if (waitCnt > 200) begin
                abortOnTimeout("arready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        waitCnt = 0;
        @(negedge clk);
        // histogram reads can sit behind a scan
        while (!rvalid) begin
            waitCnt++;
            if (waitCnt > 400) begin
                abortOnTimeout("rvalid");
            end
            @(negedge clk);
        end
        data = rdata;
        if (hold > 0) begin
            repeat (hold) @(posedge clk);
            #2;
            checkEq("rvalid", 32'(rvalid), 32'h1);
            rready = 1'b1;
        end
        @(posedge clk);
        #2;
    endtask

    // offer one hit and count it in the model on the accepting edge
    task automatic sendHit(input hitT h);
        int waitCnt;
        hitValid = 1'b1;
        hit      = h;
        waitCnt  = 0;
        @(negedge clk);
        while (!hitReady) begin
            waitCnt++;
            if (waitCnt > 1000) begin
                abortOnTimeout("hitReady");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        model[int'({h.pixel, h.bin})]++;
        expHits++;
        hitValid = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic waitStatusLow(input int bitIdx, input string what);
        int waitCnt;
        logic [31:0] st;
        waitCnt = 0;
        readReg(regStatus, 0, st);
        while (st[bitIdx]) begin
            waitCnt++;
            if (waitCnt > 200) begin
                abortOnTimeout(what);
            end
            readReg(regStatus, 0, st);
        end
    endtask

    task automatic checkAllWords();
        logic [31:0] v;
        for (int a = 0; a < pixNum*binNum; a++) begin
            readReg(regHistBase + 32'(a*4), 0, v);
            checkEq($sformatf("hist[%0d]", a), v, 32'(model[a]));
        end
        readReg(regHitCount, 0, v);
        checkEq("hitCount", v, 32'(expHits));
    endtask

    // first bin with the largest count wins
    function automatic logic [31:0] expectedPeak(input int p);
        int bestBin;
        int bestCnt;
        bestBin = 0;
        bestCnt = model[p*binNum];
        for (int b = 1; b < binNum; b++) begin
            if (model[p*binNum+b] > bestCnt) begin
                bestBin = b;
                bestCnt = model[p*binNum+b];
            end
        end
        return {bestCnt[15:0], 12'b0, bestBin[3:0]};
    endfunction

    task automatic checkPeaks();
        logic [31:0] v;
        for (int p = 0; p < pixNum; p++) begin
            readReg(regPeakBase + 32'(p*4), 0, v);
            checkEq($sformatf("peak[%0d]", p), v, expectedPeak(p));
        end
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] r;
        clk      = 1'b0;
        res      = 1'b0;
        hitValid = 1'b0;
        hit      = '0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        errCnt   = 0;
        checkCnt = 0;
        expHits  = 0;
        seed     = 32'h5bce_06cd;
        for (int a = 0; a < pixNum*binNum; a++) begin
            model[a] = 0;
        end
        repeat (4) @(posedge clk);
        #2;
        res = 1'b1;

        // quiet outputs out of reset
        checkEq("bvalid", 32'(bvalid), 32'h0);
        checkEq("rvalid", 32'(rvalid), 32'h0);
        checkEq("hitReady", 32'(hitReady), 32'h0);
        readReg(regStatus, 0, v);
        checkEq("status", v, 32'h0);

        // clear sweep
        writeReg(regCtrl, 32'h1, 0);
        readReg(regStatus, 0, v);
        checkEq("clearBusy", 32'(v[0]), 32'h1);
        waitStatusLow(0, "end of clear");
        checkAllWords();

        // random hits with random gaps
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            sendHit(hitT'(r[5:0]));
            if (r[9:8] == 2'b00) begin
                idleCycles(1 + int'(r[11:10]));
            end
        end
        checkAllWords();

        // same bin back to back and then two bins alternating
        for (int i = 0; i < 20; i++) begin
            sendHit(hitT'(6'h25));
        end
        for (int i = 0; i < 20; i++) begin
            sendHit(i[0] ? hitT'(6'h36) : hitT'(6'h31));
        end
        checkAllWords();

        // peak scan
        writeReg(regCtrl, 32'h2, 0);
        waitStatusLow(1, "end of peak scan");
        readReg(regStatus, 0, v);
        checkEq("status", v, 32'h4);
        checkPeaks();

        // hits offered during a scan wait for it
        writeReg(regCtrl, 32'h2, 0);
        readReg(regStatus, 0, v);
        checkEq("status", v, 32'h2);
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            sendHit(hitT'(r[5:0]));
        end
        waitStatusLow(1, "end of peak scan");
        readReg(regStatus, 0, v);
        checkEq("peakDone", 32'(v[2]), 32'h1);
        checkAllWords();

        // back-pressure on both response channels
        writeReg(32'h0000_0040, 32'h0, 5);
        readReg(regHitCount, 5, v);
        checkEq("hitCount", v, 32'(expHits));
        readReg(regHistBase + 32'h94, 4, v);
        checkEq("hist[37]", v, 32'(model[37]));

        idleCycles(5);
        $display("checks %0d errors %0d", checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
common/histPkg.sv
verilog/histRam.sv
verilog/ramArbiter.sv
histBuilder/histBuilder.sv
peakFinder/peakFinder.sv
verilog/axiLiteRegs.sv
verilog/histTop.sv
tb/histTb.sv

//--- run.sh
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module histTb -f src.f -o histSim

out=$(./obj_dir/histSim)
echo "$out"

# pass only if the testbench printed the pass line
echo "$out" | grep -qx "TESTS PASSED"
